// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int TAG_BITS = 8;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1;
	localparam logic [3:0] ALU_SLL  = 4'd2;
	localparam logic [3:0] ALU_SLT  = 4'd3;
	localparam logic [3:0] ALU_SLTU = 4'd4;
	localparam logic [3:0] ALU_XOR  = 4'd5;
	localparam logic [3:0] ALU_SRL  = 4'd6;
	localparam logic [3:0] ALU_SRA  = 4'd7;
	localparam logic [3:0] ALU_OR   = 4'd8;
	localparam logic [3:0] ALU_AND  = 4'd9;
	// branch compares, result in bit 0
	localparam logic [3:0] ALU_EQ   = 4'd10;
	localparam logic [3:0] ALU_NE   = 4'd11;
	localparam logic [3:0] ALU_LT   = 4'd12;
	localparam logic [3:0] ALU_GE   = 4'd13;
	localparam logic [3:0] ALU_LTU  = 4'd14;
	localparam logic [3:0] ALU_GEU  = 4'd15;

	localparam logic [2:0] SEL_ZERO = 3'd0;
	localparam logic [2:0] SEL_RS1  = 3'd1;
	localparam logic [2:0] SEL_RS2  = 3'd2;
	localparam logic [2:0] SEL_PC   = 3'd3;
	localparam logic [2:0] SEL_IMM  = 3'd4;

	localparam logic [2:0] MEM_BYTE = 3'd0;
	localparam logic [2:0] MEM_HALF = 3'd1;
	localparam logic [2:0] MEM_WORD = 3'd2;

	// one instruction word, one view per base format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rv_instr_u;

endpackage

`default_nettype wire

// ==== logic/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if;

	logic valid;
	logic busy;

	logic [31:0] pc;
	logic [rv_pkg::TAG_BITS-1:0] tag;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [31:0] imm;

	logic [3:0] alu_op;
	logic [2:0] operand1;
	logic [2:0] operand2;

	logic is_arith;
	logic is_compare;
	logic is_jump;
	logic is_branch;

	logic mem_read;
	logic mem_write;
	logic [2:0] mem_width;
	logic mem_signed;

	modport decoder (
		output valid, pc, tag, rs1, rs2, rd, imm, alu_op, operand1, operand2,
		output is_arith, is_compare, is_jump, is_branch,
		output mem_read, mem_write, mem_width, mem_signed,
		input busy
	);

	modport execute (
		input valid, pc, tag, rs1, rs2, rd, imm, alu_op, operand1, operand2,
		input is_arith, is_compare, is_jump, is_branch,
		input mem_read, mem_write, mem_width, mem_signed,
		output busy
	);

endinterface

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
	input wire i_clock,
	input wire i_reset,
	input wire i_fetch_valid,
	input wire [31:0] i_instruction,
	input wire [31:0] i_pc,
	input wire [rv_pkg::TAG_BITS-1:0] i_tag,
	output logic o_busy,
	output logic o_fault,
	decode_if.decoder dec
);

	rv_pkg::rv_instr_u word;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [3:0] reg_alu;
	logic legal;
	logic has_rs1;
	logic has_rs2;
	logic has_rd;
	logic [31:0] imm;
	logic [3:0] alu_op;
	logic [2:0] sel1;
	logic [2:0] sel2;
	logic arith;
	logic compare;
	logic jump;
	logic branch;
	logic load;
	logic store;
	logic [2:0] mem_width;
	logic held;
	logic accept;

	assign word = i_instruction;

	assign imm_i = {{20{word.i.imm[11]}}, word.i.imm};
	assign imm_s = {{20{word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
	assign imm_b = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11, word.b.imm_10_5,
		word.b.imm_4_1, 1'b0};
	assign imm_u = {word.u.imm, 12'd0};
	assign imm_j = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12, word.j.imm_11,
		word.j.imm_10_1, 1'b0};

	// item waits here until execute takes it
	assign held = dec.valid && dec.busy;
	assign o_busy = dec.busy || held;
	assign accept = i_fetch_valid && !o_busy;

	// funct7 bit 5 selects sub (register form only) and sra
	always_comb begin
		case (word.r.funct3)
			3'b000: reg_alu = (word.r.opcode == rv_pkg::OPC_OP && word.r.funct7[5]) ?
				rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: reg_alu = rv_pkg::ALU_SLL;
			3'b010: reg_alu = rv_pkg::ALU_SLT;
			3'b011: reg_alu = rv_pkg::ALU_SLTU;
			3'b100: reg_alu = rv_pkg::ALU_XOR;
			3'b101: reg_alu = word.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: reg_alu = rv_pkg::ALU_OR;
			default: reg_alu = rv_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		legal = 1'b1;
		has_rs1 = 1'b0;
		has_rs2 = 1'b0;
		has_rd = 1'b0;
		imm = 32'd0;
		alu_op = rv_pkg::ALU_ADD;
		sel1 = rv_pkg::SEL_RS1;
		sel2 = rv_pkg::SEL_IMM;
		arith = 1'b0;
		compare = 1'b0;
		jump = 1'b0;
		branch = 1'b0;
		load = 1'b0;
		store = 1'b0;
		case (word.r.opcode)
			rv_pkg::OPC_LUI: begin
				has_rd = 1'b1;
				imm = imm_u;
				sel1 = rv_pkg::SEL_ZERO;
				arith = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				has_rd = 1'b1;
				imm = imm_u;
				sel1 = rv_pkg::SEL_PC;
				arith = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				has_rd = 1'b1;
				imm = imm_j;
				sel1 = rv_pkg::SEL_PC;
				jump = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				has_rs1 = 1'b1;
				has_rd = 1'b1;
				imm = imm_i;
				jump = 1'b1;
				legal = word.i.funct3 == 3'b000;
			end
			rv_pkg::OPC_BRANCH: begin
				has_rs1 = 1'b1;
				has_rs2 = 1'b1;
				imm = imm_b;
				sel2 = rv_pkg::SEL_RS2;
				branch = 1'b1;
				case (word.b.funct3)
					3'b000: alu_op = rv_pkg::ALU_EQ;
					3'b001: alu_op = rv_pkg::ALU_NE;
					3'b100: alu_op = rv_pkg::ALU_LT;
					3'b101: alu_op = rv_pkg::ALU_GE;
					3'b110: alu_op = rv_pkg::ALU_LTU;
					3'b111: alu_op = rv_pkg::ALU_GEU;
					default: legal = 1'b0;
				endcase
			end
			rv_pkg::OPC_LOAD: begin
				has_rs1 = 1'b1;
				has_rd = 1'b1;
				imm = imm_i;
				load = 1'b1;
				// lb lh lw lbu lhu
				legal = word.i.funct3[1:0] != 2'b11 && word.i.funct3[2:1] != 2'b11;
			end
			rv_pkg::OPC_STORE: begin
				has_rs1 = 1'b1;
				has_rs2 = 1'b1;
				imm = imm_s;
				store = 1'b1;
				legal = !word.s.funct3[2] && word.s.funct3[1:0] != 2'b11;
			end
			rv_pkg::OPC_OP_IMM: begin
				has_rs1 = 1'b1;
				has_rd = 1'b1;
				imm = imm_i;
				alu_op = reg_alu;
				compare = word.i.funct3[2:1] == 2'b01;
				arith = !compare;
				if (word.i.funct3 == 3'b001)
					legal = word.r.funct7 == 7'b0000000;
				else if (word.i.funct3 == 3'b101)
					legal = word.r.funct7 == 7'b0000000 || word.r.funct7 == 7'b0100000;
			end
			rv_pkg::OPC_OP: begin
				has_rs1 = 1'b1;
				has_rs2 = 1'b1;
				has_rd = 1'b1;
				sel2 = rv_pkg::SEL_RS2;
				alu_op = reg_alu;
				compare = word.r.funct3[2:1] == 2'b01;
				arith = !compare;
				// base set only, the M extension lands here as illegal
				legal = word.r.funct7 == 7'b0000000 || (word.r.funct7 == 7'b0100000 &&
					(word.r.funct3 == 3'b000 || word.r.funct3 == 3'b101));
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		case (word.i.funct3[1:0])
			2'b00: mem_width = rv_pkg::MEM_BYTE;
			2'b01: mem_width = rv_pkg::MEM_HALF;
			default: mem_width = rv_pkg::MEM_WORD;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			dec.valid <= 1'b0;
			o_fault <= 1'b0;
		end
		else begin
			if (!held)
				dec.valid <= 1'b0;
			if (accept) begin
				dec.valid <= legal;
				if (!legal)
					o_fault <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			dec.pc <= i_pc;
			dec.tag <= i_tag;
			dec.rs1 <= has_rs1 ? word.r.rs1 : 5'd0;
			dec.rs2 <= has_rs2 ? word.r.rs2 : 5'd0;
			dec.rd <= has_rd ? word.r.rd : 5'd0;
			dec.imm <= imm;
			dec.alu_op <= alu_op;
			dec.operand1 <= sel1;
			dec.operand2 <= sel2;
			dec.is_arith <= arith;
			dec.is_compare <= compare;
			dec.is_jump <= jump;
			dec.is_branch <= branch;
			dec.mem_read <= load;
			dec.mem_write <= store;
			dec.mem_width <= (load || store) ? mem_width : rv_pkg::MEM_BYTE;
			dec.mem_signed <= load && !word.i.funct3[2];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
	input wire i_clock,
	input wire i_reset,
	input wire [4:0] i_rs1,
	input wire [4:0] i_rs2,
	output logic [31:0] o_rs1_data,
	output logic [31:0] o_rs2_data,
	input wire i_write,
	input wire [4:0] i_rd,
	input wire [31:0] i_rd_data
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	// a write in the same cycle is forwarded to the reader
	function automatic logic [31:0] read_port(input logic [4:0] index);
		if (index == 5'd0)
			return 32'd0;
		if (i_write && index == i_rd)
			return i_rd_data;
		return regs[index];
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int n = 1; n < 32; n++) begin
				regs[n] <= 32'd0;
			end
		end
		else if (i_write && i_rd != 5'd0) begin
			regs[i_rd] <= i_rd_data;
		end
	end

	always_comb begin
		o_rs1_data = read_port(i_rs1);
		o_rs2_data = read_port(i_rs2);
	end

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
	input wire i_clock,
	input wire i_reset,
	decode_if.execute dec,
	output logic [4:0] o_rs1,
	output logic [4:0] o_rs2,
	input wire [31:0] i_rs1_data,
	input wire [31:0] i_rs2_data,
	output logic o_write,
	output logic [4:0] o_rd,
	output logic [31:0] o_rd_data,
	output logic o_valid,
	output logic [rv_pkg::TAG_BITS-1:0] o_tag,
	output logic [31:0] o_pc,
	output logic [4:0] o_rd_index,
	output logic [31:0] o_result,
	output logic o_redirect,
	output logic [31:0] o_target
);

	logic take;
	logic active;
	logic finish;
	logic [31:0] sel_a;
	logic [31:0] sel_b;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] st_pc;
	logic [31:0] st_imm;
	logic [rv_pkg::TAG_BITS-1:0] st_tag;
	logic [4:0] st_rd;
	logic [3:0] st_alu;
	logic st_write;
	logic st_jump;
	logic st_jalr;
	logic st_branch;
	logic [4:0] shift_count;
	logic is_shift;
	logic [31:0] alu_out;
	logic [31:0] result;
	logic redirect;
	logic [31:0] target;

	function automatic logic [31:0] pick(
		input logic [2:0] sel,
		input logic [31:0] rs1,
		input logic [31:0] rs2,
		input logic [31:0] pc,
		input logic [31:0] imm
	);
		case (sel)
			rv_pkg::SEL_RS1: return rs1;
			rv_pkg::SEL_RS2: return rs2;
			rv_pkg::SEL_PC: return pc;
			rv_pkg::SEL_IMM: return imm;
			default: return 32'd0;
		endcase
	endfunction

	assign o_rs1 = dec.rs1;
	assign o_rs2 = dec.rs2;
	assign sel_a = pick(dec.operand1, i_rs1_data, i_rs2_data, dec.pc, dec.imm);
	assign sel_b = pick(dec.operand2, i_rs1_data, i_rs2_data, dec.pc, dec.imm);

	assign is_shift = st_alu == rv_pkg::ALU_SLL || st_alu == rv_pkg::ALU_SRL ||
		st_alu == rv_pkg::ALU_SRA;
	assign finish = active && !(is_shift && shift_count != 5'd0);
	assign dec.busy = active && !finish;
	assign take = dec.valid && !dec.busy;

	always_comb begin
		case (st_alu)
			rv_pkg::ALU_ADD: alu_out = op_a + op_b;
			rv_pkg::ALU_SUB: alu_out = op_a - op_b;
			rv_pkg::ALU_SLT, rv_pkg::ALU_LT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU, rv_pkg::ALU_LTU: alu_out = {31'd0, op_a < op_b};
			rv_pkg::ALU_XOR: alu_out = op_a ^ op_b;
			rv_pkg::ALU_OR: alu_out = op_a | op_b;
			rv_pkg::ALU_AND: alu_out = op_a & op_b;
			rv_pkg::ALU_EQ: alu_out = {31'd0, op_a == op_b};
			rv_pkg::ALU_NE: alu_out = {31'd0, op_a != op_b};
			rv_pkg::ALU_GE: alu_out = {31'd0, $signed(op_a) >= $signed(op_b)};
			rv_pkg::ALU_GEU: alu_out = {31'd0, op_a >= op_b};
			// shifts have already been applied to op_a
			default: alu_out = op_a;
		endcase
	end

	assign result = st_jump ? st_pc + 32'd4 : alu_out;
	assign redirect = st_jump || (st_branch && alu_out[0]);
	assign target = st_jalr ? {alu_out[31:1], 1'b0} : st_pc + st_imm;

	assign o_write = finish && st_write;
	assign o_rd = st_rd;
	assign o_rd_data = result;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			active <= 1'b0;
			o_valid <= 1'b0;
			o_redirect <= 1'b0;
		end
		else begin
			o_valid <= finish;
			o_redirect <= finish && redirect;
			if (take)
				active <= 1'b1;
			else if (finish)
				active <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			op_a <= sel_a;
			op_b <= sel_b;
			shift_count <= sel_b[4:0];
			st_pc <= dec.pc;
			st_imm <= dec.imm;
			st_tag <= dec.tag;
			st_rd <= dec.rd;
			st_alu <= dec.alu_op;
			st_write <= dec.is_arith || dec.is_compare || dec.is_jump;
			st_jump <= dec.is_jump;
			st_jalr <= dec.is_jump && dec.operand1 == rv_pkg::SEL_RS1;
			st_branch <= dec.is_branch;
		end
		else if (active && !finish) begin
			// one bit per cycle
			shift_count <= shift_count - 5'd1;
			case (st_alu)
				rv_pkg::ALU_SLL: op_a <= {op_a[30:0], 1'b0};
				rv_pkg::ALU_SRL: op_a <= {1'b0, op_a[31:1]};
				default: op_a <= {op_a[31], op_a[31:1]};
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (finish) begin
			o_tag <= st_tag;
			o_pc <= st_pc;
			o_rd_index <= st_write ? st_rd : 5'd0;
			o_result <= result;
			o_target <= target;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
	input wire i_clock,
	input wire i_reset,
	input wire i_fetch_valid,
	input wire [31:0] i_instruction,
	input wire [31:0] i_pc,
	input wire [rv_pkg::TAG_BITS-1:0] i_tag,
	output logic o_busy,
	output logic o_fault,
	output logic o_valid,
	output logic [rv_pkg::TAG_BITS-1:0] o_tag,
	output logic [31:0] o_pc,
	output logic [4:0] o_rd_index,
	output logic [31:0] o_result,
	output logic o_redirect,
	output logic [31:0] o_target
);

	decode_if dec_if ();

	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic write;
	logic [4:0] rd;
	logic [31:0] rd_data;

	rv_decoder rv_decoder_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_valid(i_fetch_valid),
		.i_instruction(i_instruction),
		.i_pc(i_pc),
		.i_tag(i_tag),
		.o_busy(o_busy),
		.o_fault(o_fault),
		.dec(dec_if.decoder)
	);

	rv_regfile rv_regfile_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_write(write),
		.i_rd(rd),
		.i_rd_data(rd_data)
	);

	rv_execute rv_execute_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.dec(dec_if.execute),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_write(write),
		.o_rd(rd),
		.o_rd_data(rd_data),
		.o_valid(o_valid),
		.o_tag(o_tag),
		.o_pc(o_pc),
		.o_rd_index(o_rd_index),
		.o_result(o_result),
		.o_redirect(o_redirect),
		.o_target(o_target)
	);

endmodule

`default_nettype wire

// ==== sim/rv_core_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_assert (
	input wire i_clock,
	input wire i_reset,
	input wire i_busy,
	input wire i_valid,
	input wire i_fault,
	input wire [rv_pkg::TAG_BITS-1:0] i_tag
);

	// back-to-back results are allowed, a repeated tag is not
	valid_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_valid |=> !i_valid || i_tag != $past(i_tag))
		else $error("o_valid held for two cycles on the same result");

	idle_after_reset: assert property (@(posedge i_clock)
		i_reset |=> !i_busy && !i_valid)
		else $error("o_busy or o_valid high in the cycle after reset");

	// sticky until the next reset
	fault_sticky: assert property (@(posedge i_clock)
		i_fault && !i_reset |=> i_fault || i_reset)
		else $error("o_fault fell without a reset");

endmodule

bind rv_core_top rv_core_assert rv_core_assert_i (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_busy(o_busy),
	.i_valid(o_valid),
	.i_fault(o_fault),
	.i_tag(o_tag)
);

`default_nettype wire

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

	localparam int NUM_ENTRIES = 31;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 100;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam int KIND_ALU = 0;
	localparam int KIND_JUMP = 1;
	localparam int KIND_BRANCH = 2;
	localparam int KIND_MEM = 3;
	localparam int KIND_ILLEGAL = 4;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_fetch_valid;
	logic [31:0] i_instruction;
	logic [31:0] i_pc;
	logic [rv_pkg::TAG_BITS-1:0] i_tag;
	wire o_busy;
	wire o_fault;
	wire o_valid;
	wire [rv_pkg::TAG_BITS-1:0] o_tag;
	wire [31:0] o_pc;
	wire [4:0] o_rd_index;
	wire [31:0] o_result;
	wire o_redirect;
	wire [31:0] o_target;

	// one row of stimulus and expected values per instruction
	string names [NUM_ENTRIES];
	logic [31:0] words [NUM_ENTRIES];
	logic [31:0] pcs [NUM_ENTRIES];
	logic [rv_pkg::TAG_BITS-1:0] tags [NUM_ENTRIES];
	logic [31:0] results [NUM_ENTRIES];
	logic [4:0] rd_indexes [NUM_ENTRIES];
	logic redirects [NUM_ENTRIES];
	logic [31:0] targets [NUM_ENTRIES];
	int kinds [NUM_ENTRIES];
	logic fault_before [NUM_ENTRIES];
	logic back_to_back [NUM_ENTRIES];

	int fill_count = 0;
	logic fault_seen = 1'b0;
	int expected_count = 0;
	int results_seen = 0;
	int next_entry = 0;
	int error_count = 0;
	logic [31:0] rng_state = 32'h50ca_8f97;

	rv_core_top rv_core_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_valid(i_fetch_valid),
		.i_instruction(i_instruction),
		.i_pc(i_pc),
		.i_tag(i_tag),
		.o_busy(o_busy),
		.o_fault(o_fault),
		.o_valid(o_valid),
		.o_tag(o_tag),
		.o_pc(o_pc),
		.o_rd_index(o_rd_index),
		.o_result(o_result),
		.o_redirect(o_redirect),
		.o_target(o_target)
	);

	always #2 i_clock = ~i_clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rv_pkg::rv_instr_u w;
		w.r.funct7 = f7;
		w.r.rs2 = rs2;
		w.r.rs1 = rs1;
		w.r.funct3 = f3;
		w.r.rd = rd;
		w.r.opcode = rv_pkg::OPC_OP;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		rv_pkg::rv_instr_u w;
		w.i.imm = imm;
		w.i.rs1 = rs1;
		w.i.funct3 = f3;
		w.i.rd = rd;
		w.i.opcode = opc;
		return w;
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		rv_pkg::rv_instr_u w;
		w.s.imm_11_5 = imm[11:5];
		w.s.rs2 = rs2;
		w.s.rs1 = rs1;
		w.s.funct3 = f3;
		w.s.imm_4_0 = imm[4:0];
		w.s.opcode = rv_pkg::OPC_STORE;
		return w;
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		rv_pkg::rv_instr_u w;
		w.b.imm_12 = imm[12];
		w.b.imm_10_5 = imm[10:5];
		w.b.rs2 = rs2;
		w.b.rs1 = rs1;
		w.b.funct3 = f3;
		w.b.imm_4_1 = imm[4:1];
		w.b.imm_11 = imm[11];
		w.b.opcode = rv_pkg::OPC_BRANCH;
		return w;
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		rv_pkg::rv_instr_u w;
		w.u.imm = imm;
		w.u.rd = rd;
		w.u.opcode = opc;
		return w;
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		rv_pkg::rv_instr_u w;
		w.j.imm_20 = imm[20];
		w.j.imm_10_1 = imm[10:1];
		w.j.imm_11 = imm[11];
		w.j.imm_19_12 = imm[19:12];
		w.j.rd = rd;
		w.j.opcode = rv_pkg::OPC_JAL;
		return w;
	endfunction

	// pc and tag follow from the row number
	task automatic add_entry(input string name, input logic [31:0] word,
		input logic [31:0] result, input logic [4:0] rd, input logic redirect,
		input logic [31:0] target, input int kind);
		names[fill_count] = name;
		words[fill_count] = word;
		pcs[fill_count] = 32'h100 + 32'(4 * fill_count);
		tags[fill_count] = rv_pkg::TAG_BITS'(fill_count);
		results[fill_count] = result;
		rd_indexes[fill_count] = rd;
		redirects[fill_count] = redirect;
		targets[fill_count] = target;
		kinds[fill_count] = kind;
		fault_before[fill_count] = fault_seen;
		back_to_back[fill_count] = 1'b0;
		if (kind == KIND_ILLEGAL)
			fault_seen = 1'b1;
		else
			expected_count = expected_count + 1;
		fill_count = fill_count + 1;
	endtask

	// next row follows with no idle cycles so that its operand read meets the writeback
	task automatic mark_back_to_back();
		back_to_back[fill_count - 1] = 1'b1;
	endtask

	task automatic build_table();
		add_entry("addi", i_word(12'h123, 0, 3'b000, 1, rv_pkg::OPC_OP_IMM),
			32'h123, 1, 0, 0, KIND_ALU);
		mark_back_to_back();
		add_entry("addi_bypass", i_word(12'hfff, 1, 3'b000, 2, rv_pkg::OPC_OP_IMM),
			32'h122, 2, 0, 0, KIND_ALU);
		add_entry("lui", u_word(20'h80001, 3, rv_pkg::OPC_LUI), 32'h8000_1000, 3, 0, 0, KIND_ALU);
		add_entry("auipc", u_word(20'h00010, 4, rv_pkg::OPC_AUIPC), 32'h0001_010c, 4, 0, 0,
			KIND_ALU);
		add_entry("add", r_word(7'h00, 2, 1, 3'b000, 5), 32'h245, 5, 0, 0, KIND_ALU);
		add_entry("sub", r_word(7'h20, 1, 2, 3'b000, 6), 32'hffff_ffff, 6, 0, 0, KIND_ALU);
		add_entry("slt", r_word(7'h00, 1, 6, 3'b010, 7), 32'h1, 7, 0, 0, KIND_ALU);
		add_entry("sltu", r_word(7'h00, 1, 6, 3'b011, 8), 32'h0, 8, 0, 0, KIND_ALU);
		add_entry("xor", r_word(7'h00, 1, 3, 3'b100, 9), 32'h8000_1123, 9, 0, 0, KIND_ALU);
		add_entry("or", r_word(7'h00, 4, 1, 3'b110, 10), 32'h0001_012f, 10, 0, 0, KIND_ALU);
		add_entry("and", r_word(7'h00, 9, 3, 3'b111, 11), 32'h8000_1000, 11, 0, 0, KIND_ALU);
		add_entry("sll", r_word(7'h00, 2, 1, 3'b001, 12), 32'h48c, 12, 0, 0, KIND_ALU);
		add_entry("slli_31", i_word(12'h01f, 1, 3'b001, 13, rv_pkg::OPC_OP_IMM),
			32'h8000_0000, 13, 0, 0, KIND_ALU);
		add_entry("srli_12", i_word(12'h00c, 3, 3'b101, 14, rv_pkg::OPC_OP_IMM),
			32'h0008_0001, 14, 0, 0, KIND_ALU);
		add_entry("srai_31", i_word(12'h41f, 3, 3'b101, 15, rv_pkg::OPC_OP_IMM),
			32'hffff_ffff, 15, 0, 0, KIND_ALU);
		add_entry("sra", r_word(7'h20, 7, 3, 3'b101, 16), 32'hc000_0800, 16, 0, 0, KIND_ALU);
		add_entry("srl", r_word(7'h00, 5, 9, 3'b101, 17), 32'h0400_0089, 17, 0, 0, KIND_ALU);
		add_entry("after_shift", i_word(12'h000, 13, 3'b000, 18, rv_pkg::OPC_OP_IMM),
			32'h8000_0000, 18, 0, 0, KIND_ALU);
		add_entry("jal", j_word(21'h40, 19), 32'h14c, 19, 1, 32'h188, KIND_JUMP);
		add_entry("jalr", i_word(12'h010, 1, 3'b000, 20, rv_pkg::OPC_JALR),
			32'h150, 20, 1, 32'h132, KIND_JUMP);
		add_entry("beq_taken", b_word(13'h008, 1, 1, 3'b000), 0, 0, 1, 32'h158, KIND_BRANCH);
		add_entry("bne_not_taken", b_word(13'h008, 1, 1, 3'b001), 0, 0, 0, 32'h15c,
			KIND_BRANCH);
		add_entry("blt_taken", b_word(13'h1ff0, 1, 6, 3'b100), 0, 0, 1, 32'h148, KIND_BRANCH);
		add_entry("bgeu_not_taken", b_word(13'h020, 6, 1, 3'b111), 0, 0, 0, 32'h17c,
			KIND_BRANCH);
		add_entry("lw", i_word(12'h008, 1, 3'b010, 21, rv_pkg::OPC_LOAD), 32'h12b, 0, 0, 0,
			KIND_MEM);
		add_entry("sw", s_word(12'hffc, 5, 1, 3'b010), 32'h11f, 0, 0, 0, KIND_MEM);
		add_entry("load_rd_kept", i_word(12'h000, 21, 3'b000, 22, rv_pkg::OPC_OP_IMM),
			32'h0, 22, 0, 0, KIND_ALU);
		add_entry("store_rs2_kept", i_word(12'h000, 5, 3'b000, 23, rv_pkg::OPC_OP_IMM),
			32'h245, 23, 0, 0, KIND_ALU);
		add_entry("ecall", i_word(12'h000, 0, 3'b000, 0, OPC_SYSTEM), 0, 0, 0, 0, KIND_ILLEGAL);
		add_entry("addi_after_fault", i_word(12'h007, 0, 3'b000, 24, rv_pkg::OPC_OP_IMM),
			32'h7, 24, 0, 0, KIND_ALU);
		add_entry("add_after_fault", r_word(7'h00, 24, 24, 3'b000, 25), 32'he, 25, 0, 0,
			KIND_ALU);
	endtask

	task automatic stop_with_failure();
		error_count = error_count + 1;
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error %s %s: expected %h, actual %h", name, field, expected, actual);
		stop_with_failure();
	endtask

	task automatic plain_error(input string what);
		$display("Error: %s", what);
		stop_with_failure();
	endtask

	// inputs held until an edge with o_busy low takes the word
	task automatic drive_word(input int n);
		logic was_busy;
		i_fetch_valid = 1'b1;
		i_instruction = words[n];
		i_pc = pcs[n];
		i_tag = tags[n];
		was_busy = 1'b1;
		while (was_busy) begin
			was_busy = o_busy;
			@(posedge i_clock);
			#1;
		end
		i_fetch_valid = 1'b0;
	endtask

	initial begin : stimulus
		int gap;
		i_reset = 1'b1;
		i_fetch_valid = 1'b0;
		i_instruction = 32'd0;
		i_pc = 32'd0;
		i_tag = '0;
		build_table();
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		assert (!o_fault) else plain_error("o_fault high after the first reset");
		for (int n = 0; n < NUM_ENTRIES; n++) begin
			drive_word(n);
			rng_state = xorshift32(rng_state);
			gap = back_to_back[n] ? 0 : int'(rng_state[1:0]);
			repeat (gap) begin
				@(posedge i_clock);
				#1;
			end
		end
		wait (results_seen == expected_count);
		repeat (4) @(posedge i_clock);
		#1;
		assert (o_fault) else plain_error("o_fault dropped before the second reset");
		i_reset = 1'b1;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		assert (!o_fault && !o_busy) else plain_error("o_fault or o_busy high after reset");
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : check_results
		int idx;
		forever begin
			@(negedge i_clock);
			if (!i_reset && o_valid) begin
				while (next_entry < NUM_ENTRIES && kinds[next_entry] == KIND_ILLEGAL)
					next_entry = next_entry + 1;
				if (next_entry >= NUM_ENTRIES)
					plain_error("o_valid pulsed with no instruction left to retire");
				idx = next_entry;
				assert (o_tag == tags[idx])
					else value_error(names[idx], "tag", 32'(tags[idx]), 32'(o_tag));
				assert (o_pc == pcs[idx]) else value_error(names[idx], "pc", pcs[idx], o_pc);
				assert (o_rd_index == rd_indexes[idx])
					else value_error(names[idx], "rd", 32'(rd_indexes[idx]), 32'(o_rd_index));
				assert (o_redirect == redirects[idx])
					else value_error(names[idx], "redirect", 32'(redirects[idx]),
						32'(o_redirect));
				if (kinds[idx] != KIND_BRANCH)
					assert (o_result == results[idx])
						else value_error(names[idx], "result", results[idx], o_result);
				if (kinds[idx] == KIND_JUMP || kinds[idx] == KIND_BRANCH)
					assert (o_target == targets[idx])
						else value_error(names[idx], "target", targets[idx], o_target);
				if (fault_before[idx])
					assert (o_fault) else plain_error("o_fault low after an illegal word");
				next_entry = next_entry + 1;
				results_seen = results_seen + 1;
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge i_clock);
		plain_error("watchdog expired before all results arrived");
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/rv_pkg.sv
logic/decode_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core_top.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
